//--- source/pgcb_trace_settings.svh
`ifndef PGCB_TRACE_SETTINGS_SVH
`define PGCB_TRACE_SETTINGS_SVH

// CDC population fixes the record layout
`define PGCB_TRACE_ICDC 4
`define PGCB_TRACE_NCDC 4

// Record buffer depth of at most 15 for the 4-bit count
`define PGCB_TRACE_DEPTH 8

`define PGCB_TRACE_STAMP_W 16

// APB register byte offsets
`define PGCB_TRACE_ADDR_STATUS 8'h00
`define PGCB_TRACE_ADDR_TIME   8'h04
`define PGCB_TRACE_ADDR_ICDC   8'h08
`define PGCB_TRACE_ADDR_NCDC   8'h0C
`define PGCB_TRACE_ADDR_POP    8'h10
`define PGCB_TRACE_ADDR_CTRL   8'h14

`endif

//--- source/pgcb_trace_pkg.sv
`include "pgcb_trace_settings.svh"

package pgcb_trace_pkg;

    // PGCB handshake and status bits with request and ack active low
    typedef struct packed {
        logic pg_req_b;
        logic pmc_ack_b;
        logic pg_active;
        logic restore;
        logic idle;
        logic isms_unlocked;
        logic poks_deasserted;
    } pgcb_status_t;

    typedef enum logic [3:0] {
        cdc_off             = 4'h0,
        cdc_off_pending     = 4'h1,
        cdc_on_pending      = 4'h2,
        cdc_on              = 4'h3,
        cdc_cgate_pending   = 4'h4,
        cdc_cgate           = 4'h5,
        cdc_pgate_pending   = 4'h6,
        cdc_pgate           = 4'h7,
        cdc_restore         = 4'h8,
        cdc_restore_noclk   = 4'h9,
        cdc_syncoff_pending = 4'hA,
        cdc_syncoff         = 4'hB,
        cdc_syncon_ism      = 4'hC,
        cdc_force_pending   = 4'hD,
        cdc_force_ready     = 4'hE,
        cdc_error           = 4'hF
    } cdc_state_e;

    // One trace entry with the stamp in the top bits
    typedef struct packed {
        logic [`PGCB_TRACE_STAMP_W-1:0]    stamp;
        pgcb_status_t                      status;
        cdc_state_e [`PGCB_TRACE_ICDC-1:0] icdc;
        cdc_state_e [`PGCB_TRACE_NCDC-1:0] ncdc;
    } trace_rec_t;

endpackage

//--- source/trace_capture.sv
`timescale 1ns/10ps
`include "pgcb_trace_settings.svh"

module trace_capture (
    input  logic                                              pgcb_clk,
    input  logic                                              arst_n,
    input  pgcb_trace_pkg::pgcb_status_t                      pgcb_status,
    input  pgcb_trace_pkg::cdc_state_e [`PGCB_TRACE_ICDC-1:0] icdc_state,
    input  pgcb_trace_pkg::cdc_state_e [`PGCB_TRACE_NCDC-1:0] ncdc_state,
    input  logic                                              trace_enable,
    input  logic                                              clear_drops,
    input  logic                                              full,
    output logic                                              push,
    output pgcb_trace_pkg::trace_rec_t                        push_data,
    output logic [7:0]                                        drop_count
);

    import pgcb_trace_pkg::*;

    logic [`PGCB_TRACE_STAMP_W-1:0]    stamp_cnt;
    trace_rec_t                        smp_rec;
    pgcb_status_t                      prv_status;
    cdc_state_e [`PGCB_TRACE_ICDC-1:0] prv_icdc;
    cdc_state_e [`PGCB_TRACE_NCDC-1:0] prv_ncdc;
    logic                              en_smp;
    logic                              en_prv;
    logic                              changed;
    logic                              want;
    logic                              drop;

    // Free-running stamp that wraps
    always_ff @(posedge pgcb_clk or negedge arst_n) begin
        if (!arst_n) begin
            stamp_cnt <= '0;
        end else begin
            stamp_cnt <= stamp_cnt + 1'b1;
        end
    end

    // Sample stage plus the sample before it
    always_ff @(posedge pgcb_clk) begin
        smp_rec.stamp  <= stamp_cnt;
        smp_rec.status <= pgcb_status;
        smp_rec.icdc   <= icdc_state;
        smp_rec.ncdc   <= ncdc_state;
        prv_status     <= smp_rec.status;
        prv_icdc       <= smp_rec.icdc;
        prv_ncdc       <= smp_rec.ncdc;
    end

    // Enable travels with the samples so the snapshot lines up with them
    always_ff @(posedge pgcb_clk or negedge arst_n) begin
        if (!arst_n) begin
            en_smp <= 1'b0;
            en_prv <= 1'b0;
        end else begin
            en_smp <= trace_enable;
            en_prv <= en_smp;
        end
    end

    assign changed = (smp_rec.status != prv_status) ||
                     (smp_rec.icdc != prv_icdc) ||
                     (smp_rec.ncdc != prv_ncdc);

    // First enabled sample is a snapshot and later ones need a change
    assign want      = en_smp && (!en_prv || changed);
    assign push      = want && !full;
    assign drop      = want && full;
    assign push_data = smp_rec;

    always_ff @(posedge pgcb_clk or negedge arst_n) begin
        if (!arst_n) begin
            drop_count <= '0;
        end else if (clear_drops) begin
            drop_count <= '0;
        end else if (drop && (drop_count != 8'hFF)) begin
            drop_count <= drop_count + 1'b1;
        end
    end

    a_no_push_full: assert property (
        @(posedge pgcb_clk) disable iff (!arst_n) !(push && full)
    ) else $error("capture pushed into a full FIFO");

endmodule

//--- source/trace_fifo.sv
`timescale 1ns/10ps
`include "pgcb_trace_settings.svh"

module trace_fifo #(
    parameter int  DEPTH = `PGCB_TRACE_DEPTH,
    parameter type T     = logic [7:0]
) (
    input  logic       pgcb_clk,
    input  logic       arst_n,
    input  logic       push,
    input  logic       pop,
    input  T           push_data,
    output T           head_data,
    output logic       empty,
    output logic       full,
    output logic [3:0] count
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;

    always_ff @(posedge pgcb_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge pgcb_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Simultaneous push and pop leave the occupancy unchanged
    always_ff @(posedge pgcb_clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head is presented without a read request
    assign head_data = mem[rd_ptr];
    assign empty     = (count == 4'd0);
    assign full      = (count == 4'(DEPTH));

    a_no_pop_empty: assert property (
        @(posedge pgcb_clk) disable iff (!arst_n) !(pop && empty)
    ) else $error("pop from an empty FIFO");

    a_no_push_full: assert property (
        @(posedge pgcb_clk) disable iff (!arst_n) !(push && full)
    ) else $error("push into a full FIFO");

endmodule

//--- source/trace_apb_reader.sv
`timescale 1ns/10ps
`include "pgcb_trace_settings.svh"

module trace_apb_reader (
    input  logic                       pgcb_clk,
    input  logic                       arst_n,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [7:0]                 paddr,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  pgcb_trace_pkg::trace_rec_t head_data,
    input  logic                       empty,
    input  logic                       full,
    input  logic [3:0]                 count,
    input  logic [7:0]                 drop_count,
    output logic                       pop,
    output logic                       trace_enable,
    output logic                       clear_drops
);

    logic access;
    logic wr_access;
    logic mapped;
    logic read_only;
    logic pop_sel;
    logic ctrl_sel;
    logic enable_q;

    // Zero wait states
    assign pready = 1'b1;

    assign access    = psel && penable;
    assign wr_access = access && pwrite;
    assign pop_sel   = (paddr == `PGCB_TRACE_ADDR_POP);
    assign ctrl_sel  = (paddr == `PGCB_TRACE_ADDR_CTRL);

    // Address decode and read mux
    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        prdata    = '0;
        case (paddr)
            `PGCB_TRACE_ADDR_STATUS: begin
                read_only = 1'b1;
                prdata    = {16'h0, drop_count, 2'b00, full, empty, count};
            end
            `PGCB_TRACE_ADDR_TIME: begin
                read_only = 1'b1;
                prdata    = 32'({head_data.status, head_data.stamp});
            end
            `PGCB_TRACE_ADDR_ICDC: begin
                read_only = 1'b1;
                prdata    = 32'(head_data.icdc);
            end
            `PGCB_TRACE_ADDR_NCDC: begin
                read_only = 1'b1;
                prdata    = 32'(head_data.ncdc);
            end
            `PGCB_TRACE_ADDR_POP: begin
                prdata = '0;
            end
            `PGCB_TRACE_ADDR_CTRL: begin
                prdata = {31'h0, enable_q};
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    assign pslverr = access && (!mapped ||
                                (pwrite && read_only) ||
                                (pwrite && pop_sel && empty));

    // Pulses last exactly the one access cycle
    assign pop         = wr_access && pop_sel && !empty;
    assign clear_drops = wr_access && ctrl_sel && pwdata[1];

    always_ff @(posedge pgcb_clk or negedge arst_n) begin
        if (!arst_n) begin
            enable_q <= 1'b1;
        end else if (wr_access && ctrl_sel) begin
            enable_q <= pwdata[0];
        end
    end

    assign trace_enable = enable_q;

    a_pop_not_empty: assert property (
        @(posedge pgcb_clk) disable iff (!arst_n) pop |-> !empty
    ) else $error("pop issued while FIFO empty");

    // Master must go through setup before every access
    a_apb_setup: assert property (
        @(posedge pgcb_clk) disable iff (!arst_n)
        (psel && penable) |-> $past(psel && !penable)
    ) else $error("APB access without setup phase");

endmodule

//--- source/pgcb_trace_top.sv
`timescale 1ns/10ps
`include "pgcb_trace_settings.svh"

module pgcb_trace_top (
    input  logic                                              pgcb_clk,
    input  logic                                              arst_n,
    input  pgcb_trace_pkg::pgcb_status_t                      pgcb_status,
    input  pgcb_trace_pkg::cdc_state_e [`PGCB_TRACE_ICDC-1:0] icdc_state,
    input  pgcb_trace_pkg::cdc_state_e [`PGCB_TRACE_NCDC-1:0] ncdc_state,
    input  logic                                              psel,
    input  logic                                              penable,
    input  logic                                              pwrite,
    input  logic [7:0]                                        paddr,
    input  logic [31:0]                                       pwdata,
    output logic [31:0]                                       prdata,
    output logic                                              pready,
    output logic                                              pslverr
);

    import pgcb_trace_pkg::*;

    logic       push;
    trace_rec_t push_data;
    logic       full;
    logic       empty;
    logic [3:0] count;
    trace_rec_t head_data;
    logic       pop;
    logic       trace_enable;
    logic       clear_drops;
    logic [7:0] drop_count;

    trace_capture u_capture (
        .pgcb_clk     (pgcb_clk),
        .arst_n       (arst_n),
        .pgcb_status  (pgcb_status),
        .icdc_state   (icdc_state),
        .ncdc_state   (ncdc_state),
        .trace_enable (trace_enable),
        .clear_drops  (clear_drops),
        .full         (full),
        .push         (push),
        .push_data    (push_data),
        .drop_count   (drop_count)
    );

    trace_fifo #(
        .DEPTH (`PGCB_TRACE_DEPTH),
        .T     (trace_rec_t)
    ) u_fifo (
        .pgcb_clk  (pgcb_clk),
        .arst_n    (arst_n),
        .push      (push),
        .pop       (pop),
        .push_data (push_data),
        .head_data (head_data),
        .empty     (empty),
        .full      (full),
        .count     (count)
    );

    trace_apb_reader u_reader (
        .pgcb_clk     (pgcb_clk),
        .arst_n       (arst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .head_data    (head_data),
        .empty        (empty),
        .full         (full),
        .count        (count),
        .drop_count   (drop_count),
        .pop          (pop),
        .trace_enable (trace_enable),
        .clear_drops  (clear_drops)
    );

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic pgcb_clk,
    output logic arst_n
);

    initial begin
        pgcb_clk = 1'b0;
        forever #(PERIOD / 2) pgcb_clk = ~pgcb_clk;
    end

    // Release on a falling edge away from the sampling edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge pgcb_clk);
        @(negedge pgcb_clk);
        arst_n = 1'b1;
    end

endmodule

//--- sim/pgcb_trace_tb.sv
`timescale 1ns/10ps
`include "pgcb_trace_settings.svh"

module pgcb_trace_tb;

    import pgcb_trace_pkg::*;

    localparam int SEED        = 24769;
    localparam int APB_TIMEOUT = 20;
    localparam int POLL_LIMIT  = 50;
    localparam int RESET_LIMIT = 50;

    logic                              pgcb_clk;
    logic                              arst_n;
    pgcb_status_t                      pgcb_status;
    cdc_state_e [`PGCB_TRACE_ICDC-1:0] icdc_state;
    cdc_state_e [`PGCB_TRACE_NCDC-1:0] ncdc_state;
    logic                              psel;
    logic                              penable;
    logic                              pwrite;
    logic [7:0]                        paddr;
    logic [31:0]                       pwdata;
    logic [31:0]                       prdata;
    logic                              pready;
    logic                              pslverr;

    // Values currently driven and the records they should leave behind
    pgcb_status_t                      cur_status;
    cdc_state_e [`PGCB_TRACE_ICDC-1:0] cur_icdc;
    cdc_state_e [`PGCB_TRACE_NCDC-1:0] cur_ncdc;
    trace_rec_t                        exp_q[$];
    logic [15:0]                       stamp_now;

    // Expectations for the access in flight
    logic        chk_data_en;
    logic        chk_err_en;
    logic [31:0] chk_data;
    logic        chk_err;
    string       chk_name;

    int err_count    = 0;
    int test_errs    = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(5)) u_clk_gen (
        .pgcb_clk (pgcb_clk),
        .arst_n   (arst_n)
    );

    pgcb_trace_top u_dut (
        .pgcb_clk    (pgcb_clk),
        .arst_n      (arst_n),
        .pgcb_status (pgcb_status),
        .icdc_state  (icdc_state),
        .ncdc_state  (ncdc_state),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr)
    );

    // Stamp that the next sampling edge will carry
    always @(posedge pgcb_clk or negedge arst_n) begin
        if (!arst_n) begin
            stamp_now <= '0;
        end else begin
            stamp_now <= stamp_now + 16'd1;
        end
    end

    a_read_data: assert property (
        @(posedge pgcb_clk) disable iff (!arst_n)
        (psel && penable && chk_data_en) |-> (prdata == chk_data)
    ) else begin
        $display("CHECK FAILED time=%0t %s expected=%h actual=%h",
                 $time, chk_name, chk_data, $sampled(prdata));
        err_count++;
    end

    a_slave_err: assert property (
        @(posedge pgcb_clk) disable iff (!arst_n)
        (psel && penable && chk_err_en) |-> (pslverr == chk_err)
    ) else begin
        $display("CHECK FAILED time=%0t pslverr on %s expected=%b actual=%b",
                 $time, chk_name, chk_err, $sampled(pslverr));
        err_count++;
    end

    a_ready: assert property (
        @(posedge pgcb_clk) disable iff (!arst_n) (psel && penable) |-> pready
    ) else begin
        $display("CHECK FAILED time=%0t pready expected=1 actual=%b", $time, $sampled(pready));
        err_count++;
    end

    a_idle_quiet: assert property (
        @(posedge pgcb_clk) disable iff (!arst_n) !(psel && penable) |-> !pslverr
    ) else begin
        $display("CHECK FAILED time=%0t pslverr when idle expected=0 actual=1", $time);
        err_count++;
    end

    function automatic logic [31:0] status_word(input int cnt, input logic emp,
                                                input logic ful, input int drops);
        return {16'h0, 8'(drops), 2'b00, ful, emp, 4'(cnt)};
    endfunction

    function automatic logic [31:0] time_word(input trace_rec_t rec);
        return {9'h0, rec.status, rec.stamp};
    endfunction

    function automatic logic [31:0] cdc_word(input logic [15:0] states);
        return {16'h0, states};
    endfunction

    task automatic abort_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("tests run %0d, failed %0d, check errors %0d",
                 tests_run, tests_failed, err_count);
        $display("FAIL: see errors above");
        $finish;
    endtask

    // Called on the edge that opens the access phase
    task automatic access_phase(input logic wr, input logic do_data, input logic [31:0] exp_data,
                                input logic exp_err, input string name,
                                output logic [31:0] rdata);
        int waited;
        waited = 0;
        penable     <= 1'b1;
        chk_data_en <= do_data && !wr;
        chk_data    <= exp_data;
        chk_err_en  <= 1'b1;
        chk_err     <= exp_err;
        chk_name    <= name;
        @(negedge pgcb_clk);
        while (pready !== 1'b1 && waited < APB_TIMEOUT) begin
            @(negedge pgcb_clk);
            waited++;
        end
        if (pready !== 1'b1) begin
            abort_run($sformatf("APB access to %s never completed", name));
        end else begin
            rdata = prdata;
            @(posedge pgcb_clk);
            psel        <= 1'b0;
            penable     <= 1'b0;
            chk_data_en <= 1'b0;
            chk_err_en  <= 1'b0;
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            input logic do_data, input logic [31:0] exp_data,
                            input logic exp_err, input string name, output logic [31:0] rdata);
        @(posedge pgcb_clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge pgcb_clk);
        access_phase(wr, do_data, exp_data, exp_err, name, rdata);
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp_data,
                            input logic do_data, input string name, output logic [31:0] rdata);
        apb_xfer(1'b0, addr, 32'h0, do_data, exp_data, 1'b0, name, rdata);
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata,
                             input logic exp_err, input string name);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, wdata, 1'b0, 32'h0, exp_err, name, unused);
    endtask

    task automatic wait_count(input int target);
        logic [31:0] rd;
        int          polls;
        polls = 0;
        apb_read(`PGCB_TRACE_ADDR_STATUS, 32'h0, 1'b0, "STATUS poll", rd);
        while (rd[3:0] != 4'(target) && polls < POLL_LIMIT) begin
            apb_read(`PGCB_TRACE_ADDR_STATUS, 32'h0, 1'b0, "STATUS poll", rd);
            polls++;
        end
        if (rd[3:0] != 4'(target)) begin
            abort_run($sformatf("record count never reached %0d", target));
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge pgcb_clk);
        end
    endtask

    // One random change to a status bit or a CDC state
    task automatic make_change(input logic keep);
        logic [6:0] bits;
        trace_rec_t rec;
        int         kind;
        int         idx;
        kind = $urandom_range(2, 0);
        if (kind == 0) begin
            idx        = $urandom_range(6, 0);
            bits       = cur_status;
            bits[idx]  = ~bits[idx];
            cur_status = pgcb_status_t'(bits);
        end else if (kind == 1) begin
            idx           = $urandom_range(`PGCB_TRACE_ICDC - 1, 0);
            cur_icdc[idx] = cdc_state_e'(cur_icdc[idx] ^ 4'($urandom_range(15, 1)));
        end else begin
            idx           = $urandom_range(`PGCB_TRACE_NCDC - 1, 0);
            cur_ncdc[idx] = cdc_state_e'(cur_ncdc[idx] ^ 4'($urandom_range(15, 1)));
        end
        @(posedge pgcb_clk);
        pgcb_status <= cur_status;
        icdc_state  <= cur_icdc;
        ncdc_state  <= cur_ncdc;
        @(negedge pgcb_clk);
        if (keep) begin
            rec.stamp  = stamp_now;
            rec.status = cur_status;
            rec.icdc   = cur_icdc;
            rec.ncdc   = cur_ncdc;
            exp_q.push_back(rec);
        end
    endtask

    task automatic check_head_and_pop(input trace_rec_t rec, output logic [15:0] stamp_got);
        logic [31:0] rd;
        apb_read(`PGCB_TRACE_ADDR_TIME, time_word(rec), 1'b1, "prdata TIME", rd);
        stamp_got = rd[15:0];
        apb_read(`PGCB_TRACE_ADDR_ICDC, cdc_word(rec.icdc), 1'b1, "prdata ICDC", rd);
        apb_read(`PGCB_TRACE_ADDR_NCDC, cdc_word(rec.ncdc), 1'b1, "prdata NCDC", rd);
        apb_write(`PGCB_TRACE_ADDR_POP, 32'h0, 1'b0, "POP");
    endtask

    task automatic end_test(input string name);
        @(negedge pgcb_clk);
        tests_run++;
        if (err_count != test_errs) begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, err_count - test_errs);
        end else begin
            $display("test %s: ok", name);
        end
        test_errs = err_count;
    endtask

    initial begin
        trace_rec_t  rec;
        logic [31:0] rd;
        logic [15:0] first_stamp;
        int          n;
        int          waited;

        void'($urandom(SEED));
        cur_status = pgcb_status_t'(7'($urandom));
        for (int i = 0; i < `PGCB_TRACE_ICDC; i++) begin
            cur_icdc[i] = cdc_state_e'(4'($urandom));
        end
        for (int i = 0; i < `PGCB_TRACE_NCDC; i++) begin
            cur_ncdc[i] = cdc_state_e'(4'($urandom));
        end
        pgcb_status = cur_status;
        icdc_state  = cur_icdc;
        ncdc_state  = cur_ncdc;
        // Setup phase of the first STATUS read is held through reset
        psel        = 1'b1;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = `PGCB_TRACE_ADDR_STATUS;
        pwdata      = 32'h0;
        chk_data_en = 1'b0;
        chk_err_en  = 1'b0;
        chk_data    = 32'h0;
        chk_err     = 1'b0;
        chk_name    = "none";
        rec.stamp   = 16'h0;
        rec.status  = cur_status;
        rec.icdc    = cur_icdc;
        rec.ncdc    = cur_ncdc;
        exp_q.push_back(rec);

        waited = 0;
        do begin
            @(posedge pgcb_clk);
            waited++;
        end while (arst_n !== 1'b1 && waited < RESET_LIMIT);
        if (arst_n !== 1'b1) begin
            abort_run("reset was never released");
        end

        access_phase(1'b0, 1'b1, status_word(0, 1, 0, 0), 1'b0, "prdata STATUS", rd);
        wait_count(1);
        check_head_and_pop(exp_q.pop_front(), first_stamp);
        apb_read(`PGCB_TRACE_ADDR_STATUS, status_word(0, 1, 0, 0), 1'b1, "prdata STATUS", rd);
        end_test("reset and snapshot");

        make_change(1'b1);
        wait_count(1);
        apb_read(`PGCB_TRACE_ADDR_STATUS, status_word(1, 0, 0, 0), 1'b1, "prdata STATUS", rd);
        check_head_and_pop(exp_q.pop_front(), first_stamp);
        apb_read(`PGCB_TRACE_ADDR_STATUS, status_word(0, 1, 0, 0), 1'b1, "prdata STATUS", rd);
        end_test("single change");

        idle_cycles($urandom_range(40, 5));
        apb_read(`PGCB_TRACE_ADDR_STATUS, status_word(0, 1, 0, 0), 1'b1, "prdata STATUS", rd);
        end_test("steady inputs");

        n = $urandom_range(20, 2);
        make_change(1'b1);
        idle_cycles(n - 1);
        make_change(1'b1);
        wait_count(2);
        check_head_and_pop(exp_q.pop_front(), first_stamp);
        rec       = exp_q.pop_front();
        rec.stamp = first_stamp + 16'(n);
        check_head_and_pop(rec, first_stamp);
        end_test("stamp spacing");

        for (int i = 0; i < `PGCB_TRACE_DEPTH + 1; i++) begin
            make_change(1'b1);
        end
        wait_count(`PGCB_TRACE_DEPTH);
        apb_read(`PGCB_TRACE_ADDR_STATUS, status_word(`PGCB_TRACE_DEPTH, 0, 1, 1), 1'b1,
                 "prdata STATUS", rd);
        for (int i = 0; i < `PGCB_TRACE_DEPTH; i++) begin
            check_head_and_pop(exp_q.pop_front(), first_stamp);
        end
        exp_q.delete();
        apb_write(`PGCB_TRACE_ADDR_CTRL, 32'h3, 1'b0, "CTRL");
        apb_read(`PGCB_TRACE_ADDR_STATUS, status_word(0, 1, 0, 0), 1'b1, "prdata STATUS", rd);
        end_test("overflow and drop clear");

        apb_xfer(1'b0, 8'h18, 32'h0, 1'b0, 32'h0, 1'b1, "unmapped read", rd);
        apb_write(`PGCB_TRACE_ADDR_STATUS, 32'h1, 1'b1, "STATUS write");
        apb_write(`PGCB_TRACE_ADDR_POP, 32'h0, 1'b1, "POP on empty");
        apb_write(`PGCB_TRACE_ADDR_CTRL, 32'h0, 1'b0, "CTRL");
        apb_read(`PGCB_TRACE_ADDR_CTRL, 32'h0, 1'b1, "prdata CTRL", rd);
        make_change(1'b0);
        make_change(1'b0);
        idle_cycles(5);
        apb_read(`PGCB_TRACE_ADDR_STATUS, status_word(0, 1, 0, 0), 1'b1, "prdata STATUS", rd);
        end_test("errors and disable");

        $display("tests run %0d, failed %0d, check errors %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+source
source/pgcb_trace_pkg.sv
source/trace_capture.sv
source/trace_fifo.sv
source/trace_apb_reader.sv
source/pgcb_trace_top.sv
sim/tb_clock_gen.sv
sim/pgcb_trace_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= pgcb_trace_tb
RTL_TOP   ?= pgcb_trace_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= PASS: all tests

SIM_BIN := $(OBJ_DIR)/$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o $(TB_TOP)

# The run passes only when the pass line shows up in the output
sim: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
